// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] data_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;

  // first fetch address out of reset
  localparam data_t RESET_PC = 32'h0000_0000;

  // major opcodes of the supported subset
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;

  // register and immediate arithmetic
  localparam funct3_t F3_ADD = 3'b000;
  localparam funct3_t F3_XOR = 3'b100;
  localparam funct3_t F3_OR  = 3'b110;
  localparam funct3_t F3_AND = 3'b111;

  // branch compares
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;

  // sub shares funct3 with add
  localparam funct7_t F7_SUB = 7'b0100000;

endpackage

// File: hdl/rv_pipe_pkg.sv
package rv_pipe_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  typedef enum logic {
    SRC2_REG,
    SRC2_IMM
  } alu_src2_t;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  // WB_ALU is the zero encoding, so a bubble never looks like a load
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_t;

  typedef struct packed {
    data_t pc;
    data_t instr;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    data_t     pc;
    data_t     rs1_data;
    data_t     rs2_data;
    data_t     imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    alu_op_t   alu_op;
    alu_src2_t alu_src2;
    logic      branch;
    logic      branch_ne;
    logic      jump;
    logic      mem_write;
    logic      reg_write;
    wb_sel_t   wb_sel;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    data_t     alu_result;
    data_t     store_data;
    data_t     pc_plus4;
    reg_addr_t rd;
    logic      mem_write;
    logic      reg_write;
    wb_sel_t   wb_sel;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    data_t     alu_result;
    data_t     load_data;
    data_t     pc_plus4;
    reg_addr_t rd;
    logic      reg_write;
    wb_sel_t   wb_sel;
  } mem_wb_t;

endpackage

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              stall_i,
  input  logic              redirect_i,
  input  rv_isa_pkg::data_t target_i,
  output rv_isa_pkg::data_t pc_o
);

  import rv_isa_pkg::*;

  data_t pc_q;

  // taken branch or jump in execute overrides the sequential pc
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      pc_q <= target_i;
    end else if (!stall_i) begin
      pc_q <= pc_q + data_t'(4);
    end
  end

  assign pc_o = pc_q;

endmodule

// File: hdl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     stall_i,
  input  logic     flush_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // all-zero payload is a bubble: valid and every write enable low
  always_ff @(posedge clk) begin
    if (rst_i) begin
      q_o <= '0;
    end else if (flush_i) begin
      q_o <= '0;
    end else if (!stall_i) begin
      q_o <= d_i;
    end
  end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  rv_isa_pkg::data_t      instr_i,
  output rv_isa_pkg::reg_addr_t  rs1_o,
  output rv_isa_pkg::reg_addr_t  rs2_o,
  output rv_isa_pkg::reg_addr_t  rd_o,
  output rv_isa_pkg::data_t      imm_o,
  output rv_pipe_pkg::alu_op_t   alu_op_o,
  output rv_pipe_pkg::alu_src2_t alu_src2_o,
  output logic                   branch_o,
  output logic                   branch_ne_o,
  output logic                   jump_o,
  output logic                   mem_write_o,
  output logic                   reg_write_o,
  output rv_pipe_pkg::wb_sel_t   wb_sel_o
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  data_t   imm_i_type;
  data_t   imm_s_type;
  data_t   imm_b_type;
  data_t   imm_j_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd_o   = instr_i[11:7];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    // unsupported encodings fall out as a no-op
    imm_o       = '0;
    alu_op_o    = ALU_ADD;
    alu_src2_o  = SRC2_REG;
    branch_o    = 1'b0;
    branch_ne_o = 1'b0;
    jump_o      = 1'b0;
    mem_write_o = 1'b0;
    reg_write_o = 1'b0;
    wb_sel_o    = WB_ALU;
    case (opcode)
      OP_REG: begin
        reg_write_o = 1'b1;
        case (funct3)
          F3_ADD:  alu_op_o = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_XOR:  alu_op_o = ALU_XOR;
          F3_OR:   alu_op_o = ALU_OR;
          F3_AND:  alu_op_o = ALU_AND;
          default: reg_write_o = 1'b0;
        endcase
      end
      OP_IMM: begin
        // addi only
        imm_o       = imm_i_type;
        alu_src2_o  = SRC2_IMM;
        reg_write_o = (funct3 == F3_ADD);
      end
      OP_LOAD: begin
        imm_o       = imm_i_type;
        alu_src2_o  = SRC2_IMM;
        reg_write_o = 1'b1;
        wb_sel_o    = WB_MEM;
      end
      OP_STORE: begin
        imm_o       = imm_s_type;
        alu_src2_o  = SRC2_IMM;
        mem_write_o = 1'b1;
      end
      OP_BRANCH: begin
        imm_o       = imm_b_type;
        branch_o    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        branch_ne_o = (funct3 == F3_BNE);
      end
      OP_JAL: begin
        imm_o       = imm_j_type;
        jump_o      = 1'b1;
        reg_write_o = 1'b1;
        wb_sel_o    = WB_PC4;
      end
      default: ;
    endcase
  end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  we_i,
  input  rv_isa_pkg::reg_addr_t waddr_i,
  input  rv_isa_pkg::data_t     wdata_i,
  input  rv_isa_pkg::reg_addr_t raddr1_i,
  input  rv_isa_pkg::reg_addr_t raddr2_i,
  output rv_isa_pkg::data_t     rdata1_o,
  output rv_isa_pkg::data_t     rdata2_o
);

  import rv_isa_pkg::*;

  // x0 has no storage
  data_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // bypass the write in flight so decode sees the writeback value
  always_comb begin
    rdata1_o = '0;
    rdata2_o = '0;
    if (raddr1_i != '0) begin
      rdata1_o = (we_i && (raddr1_i == waddr_i)) ? wdata_i : regs[raddr1_i];
    end
    if (raddr2_i != '0) begin
      rdata2_o = (we_i && (raddr2_i == waddr_i)) ? wdata_i : regs[raddr2_i];
    end
  end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  rv_isa_pkg::data_t      pc_i,
  input  rv_isa_pkg::data_t      rs1_data_i,
  input  rv_isa_pkg::data_t      rs2_data_i,
  input  rv_isa_pkg::data_t      imm_i,
  input  rv_isa_pkg::data_t      fwd_mem_i,
  input  rv_isa_pkg::data_t      fwd_wb_i,
  input  rv_pipe_pkg::fwd_sel_t  fwd1_sel_i,
  input  rv_pipe_pkg::fwd_sel_t  fwd2_sel_i,
  input  rv_pipe_pkg::alu_op_t   alu_op_i,
  input  rv_pipe_pkg::alu_src2_t alu_src2_i,
  input  logic                   branch_i,
  input  logic                   branch_ne_i,
  input  logic                   jump_i,
  output rv_isa_pkg::data_t      alu_result_o,
  output rv_isa_pkg::data_t      store_data_o,
  output rv_isa_pkg::data_t      target_o,
  output logic                   redirect_o
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  data_t op1;
  data_t op2_reg;
  data_t op2;
  logic  equal;

  function automatic data_t pick(fwd_sel_t sel, data_t rf, data_t mem, data_t wb);
    case (sel)
      FWD_MEM: return mem;
      FWD_WB:  return wb;
      default: return rf;
    endcase
  endfunction

  assign op1     = pick(fwd1_sel_i, rs1_data_i, fwd_mem_i, fwd_wb_i);
  assign op2_reg = pick(fwd2_sel_i, rs2_data_i, fwd_mem_i, fwd_wb_i);
  assign op2     = (alu_src2_i == SRC2_IMM) ? imm_i : op2_reg;

  // stores take the forwarded rs2, not the stale decode read
  assign store_data_o = op2_reg;

  always_comb begin
    case (alu_op_i)
      ALU_SUB: alu_result_o = op1 - op2;
      ALU_AND: alu_result_o = op1 & op2;
      ALU_OR:  alu_result_o = op1 | op2;
      ALU_XOR: alu_result_o = op1 ^ op2;
      default: alu_result_o = op1 + op2;
    endcase
  end

  // beq and bne share one comparator
  assign equal      = (op1 == op2_reg);
  assign redirect_o = (branch_i && (equal ^ branch_ne_i)) || jump_i;
  assign target_o   = pc_i + imm_i;

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  rv_isa_pkg::reg_addr_t id_rs1_i,
  input  rv_isa_pkg::reg_addr_t id_rs2_i,
  input  rv_isa_pkg::reg_addr_t ex_rs1_i,
  input  rv_isa_pkg::reg_addr_t ex_rs2_i,
  input  rv_isa_pkg::reg_addr_t ex_rd_i,
  input  rv_pipe_pkg::wb_sel_t  ex_wb_sel_i,
  input  logic                  ex_redirect_i,
  input  rv_isa_pkg::reg_addr_t mem_rd_i,
  input  logic                  mem_reg_write_i,
  input  rv_isa_pkg::reg_addr_t wb_rd_i,
  input  logic                  wb_reg_write_i,
  output logic                  stall_o,
  output logic                  flush_if_id_o,
  output logic                  flush_id_ex_o,
  output rv_pipe_pkg::fwd_sel_t fwd1_sel_o,
  output rv_pipe_pkg::fwd_sel_t fwd2_sel_o
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic load_use;

  // the younger producer in memory wins over writeback
  function automatic fwd_sel_t fwd_for(reg_addr_t rs);
    if (mem_reg_write_i && (mem_rd_i != '0) && (mem_rd_i == rs)) begin
      return FWD_MEM;
    end
    if (wb_reg_write_i && (wb_rd_i != '0) && (wb_rd_i == rs)) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  assign load_use = (ex_wb_sel_i == WB_MEM) && (ex_rd_i != '0) &&
                    ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

  // hold fetch and decode, drop a bubble into execute
  assign stall_o       = load_use;
  assign flush_if_id_o = ex_redirect_i;
  assign flush_id_ex_o = ex_redirect_i || load_use;

  always_comb begin
    fwd1_sel_o = fwd_for(ex_rs1_i);
    fwd2_sel_o = fwd_for(ex_rs2_i);
  end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                  clk,
  input  logic                  rst_i,
  output rv_isa_pkg::data_t     imem_addr_o,
  input  rv_isa_pkg::data_t     imem_data_i,
  output rv_isa_pkg::data_t     dmem_addr_o,
  output rv_isa_pkg::data_t     dmem_wdata_o,
  output logic                  dmem_we_o,
  input  rv_isa_pkg::data_t     dmem_rdata_i,
  output logic                  wb_en_o,
  output rv_isa_pkg::reg_addr_t wb_rd_o,
  output rv_isa_pkg::data_t     wb_data_o
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic      stall;
  logic      flush_if_id;
  logic      flush_id_ex;
  fwd_sel_t  fwd1_sel;
  fwd_sel_t  fwd2_sel;
  data_t     pc_f;
  if_id_t    if_id_d;
  if_id_t    if_id_q;
  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  reg_addr_t id_rd;
  data_t     id_imm;
  data_t     id_rs1_data;
  data_t     id_rs2_data;
  alu_op_t   id_alu_op;
  alu_src2_t id_alu_src2;
  logic      id_branch;
  logic      id_branch_ne;
  logic      id_jump;
  logic      id_mem_write;
  logic      id_reg_write;
  wb_sel_t   id_wb_sel;
  id_ex_t    id_ex_d;
  id_ex_t    id_ex_q;
  data_t     ex_alu_result;
  data_t     ex_store_data;
  data_t     ex_target;
  logic      ex_redirect;
  ex_mem_t   ex_mem_d;
  ex_mem_t   ex_mem_q;
  data_t     mem_fwd_data;
  mem_wb_t   mem_wb_d;
  mem_wb_t   mem_wb_q;
  data_t     wb_data;
  logic      wb_write;

  fetch_stage fetch (
    .clk       (clk),
    .rst_i     (rst_i),
    .stall_i   (stall),
    .redirect_i(ex_redirect),
    .target_i  (ex_target),
    .pc_o      (pc_f)
  );

  assign imem_addr_o    = pc_f;
  assign if_id_d.pc     = pc_f;
  assign if_id_d.instr  = imem_data_i;

  pipe_reg #(.payload_t(if_id_t)) if_id_reg (
    .clk    (clk),
    .rst_i  (rst_i),
    .stall_i(stall),
    .flush_i(flush_if_id),
    .d_i    (if_id_d),
    .q_o    (if_id_q)
  );

  decode_stage decode (
    .instr_i    (if_id_q.instr),
    .rs1_o      (id_rs1),
    .rs2_o      (id_rs2),
    .rd_o       (id_rd),
    .imm_o      (id_imm),
    .alu_op_o   (id_alu_op),
    .alu_src2_o (id_alu_src2),
    .branch_o   (id_branch),
    .branch_ne_o(id_branch_ne),
    .jump_o     (id_jump),
    .mem_write_o(id_mem_write),
    .reg_write_o(id_reg_write),
    .wb_sel_o   (id_wb_sel)
  );

  reg_file regs (
    .clk     (clk),
    .rst_i   (rst_i),
    .we_i    (wb_write),
    .waddr_i (mem_wb_q.rd),
    .wdata_i (wb_data),
    .raddr1_i(id_rs1),
    .raddr2_i(id_rs2),
    .rdata1_o(id_rs1_data),
    .rdata2_o(id_rs2_data)
  );

  always_comb begin
    // a decoded no-op enters execute as an empty slot
    id_ex_d.valid     = id_reg_write | id_mem_write | id_branch | id_jump;
    id_ex_d.pc        = if_id_q.pc;
    id_ex_d.rs1_data  = id_rs1_data;
    id_ex_d.rs2_data  = id_rs2_data;
    id_ex_d.imm       = id_imm;
    id_ex_d.rs1       = id_rs1;
    id_ex_d.rs2       = id_rs2;
    id_ex_d.rd        = id_rd;
    id_ex_d.alu_op    = id_alu_op;
    id_ex_d.alu_src2  = id_alu_src2;
    id_ex_d.branch    = id_branch;
    id_ex_d.branch_ne = id_branch_ne;
    id_ex_d.jump      = id_jump;
    id_ex_d.mem_write = id_mem_write;
    id_ex_d.reg_write = id_reg_write;
    id_ex_d.wb_sel    = id_wb_sel;
  end

  pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clk    (clk),
    .rst_i  (rst_i),
    .stall_i(1'b0),
    .flush_i(flush_id_ex),
    .d_i    (id_ex_d),
    .q_o    (id_ex_q)
  );

  execute_stage execute (
    .pc_i        (id_ex_q.pc),
    .rs1_data_i  (id_ex_q.rs1_data),
    .rs2_data_i  (id_ex_q.rs2_data),
    .imm_i       (id_ex_q.imm),
    .fwd_mem_i   (mem_fwd_data),
    .fwd_wb_i    (wb_data),
    .fwd1_sel_i  (fwd1_sel),
    .fwd2_sel_i  (fwd2_sel),
    .alu_op_i    (id_ex_q.alu_op),
    .alu_src2_i  (id_ex_q.alu_src2),
    .branch_i    (id_ex_q.branch),
    .branch_ne_i (id_ex_q.branch_ne),
    .jump_i      (id_ex_q.jump),
    .alu_result_o(ex_alu_result),
    .store_data_o(ex_store_data),
    .target_o    (ex_target),
    .redirect_o  (ex_redirect)
  );

  always_comb begin
    ex_mem_d.valid      = id_ex_q.valid;
    ex_mem_d.alu_result = ex_alu_result;
    ex_mem_d.store_data = ex_store_data;
    ex_mem_d.pc_plus4   = id_ex_q.pc + data_t'(4);
    ex_mem_d.rd         = id_ex_q.rd;
    ex_mem_d.mem_write  = id_ex_q.mem_write;
    ex_mem_d.reg_write  = id_ex_q.reg_write;
    ex_mem_d.wb_sel     = id_ex_q.wb_sel;
  end

  pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
    .clk    (clk),
    .rst_i  (rst_i),
    .stall_i(1'b0),
    .flush_i(1'b0),
    .d_i    (ex_mem_d),
    .q_o    (ex_mem_q)
  );

  assign dmem_addr_o  = ex_mem_q.alu_result;
  assign dmem_wdata_o = ex_mem_q.store_data;
  assign dmem_we_o    = ex_mem_q.valid & ex_mem_q.mem_write;

  // jal result lives in pc_plus4; a load here is covered by the stall
  assign mem_fwd_data = (ex_mem_q.wb_sel == WB_PC4) ? ex_mem_q.pc_plus4 : ex_mem_q.alu_result;

  always_comb begin
    mem_wb_d.valid      = ex_mem_q.valid;
    mem_wb_d.alu_result = ex_mem_q.alu_result;
    mem_wb_d.load_data  = dmem_rdata_i;
    mem_wb_d.pc_plus4   = ex_mem_q.pc_plus4;
    mem_wb_d.rd         = ex_mem_q.rd;
    mem_wb_d.reg_write  = ex_mem_q.reg_write;
    mem_wb_d.wb_sel     = ex_mem_q.wb_sel;
  end

  pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
    .clk    (clk),
    .rst_i  (rst_i),
    .stall_i(1'b0),
    .flush_i(1'b0),
    .d_i    (mem_wb_d),
    .q_o    (mem_wb_q)
  );

  always_comb begin
    case (mem_wb_q.wb_sel)
      WB_MEM:  wb_data = mem_wb_q.load_data;
      WB_PC4:  wb_data = mem_wb_q.pc_plus4;
      default: wb_data = mem_wb_q.alu_result;
    endcase
  end

  // x0 writes never reach the commit trace
  assign wb_write  = mem_wb_q.valid & mem_wb_q.reg_write & (mem_wb_q.rd != '0);
  assign wb_en_o   = wb_write;
  assign wb_rd_o   = mem_wb_q.rd;
  assign wb_data_o = wb_data;

  hazard_unit hazard (
    .id_rs1_i       (id_rs1),
    .id_rs2_i       (id_rs2),
    .ex_rs1_i       (id_ex_q.rs1),
    .ex_rs2_i       (id_ex_q.rs2),
    .ex_rd_i        (id_ex_q.rd),
    .ex_wb_sel_i    (id_ex_q.wb_sel),
    .ex_redirect_i  (ex_redirect),
    .mem_rd_i       (ex_mem_q.rd),
    .mem_reg_write_i(ex_mem_q.valid & ex_mem_q.reg_write),
    .wb_rd_i        (mem_wb_q.rd),
    .wb_reg_write_i (mem_wb_q.valid & mem_wb_q.reg_write),
    .stall_o        (stall),
    .flush_if_id_o  (flush_if_id),
    .flush_id_ex_o  (flush_id_ex),
    .fwd1_sel_o     (fwd1_sel),
    .fwd2_sel_o     (fwd2_sel)
  );

endmodule

// File: test/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// addi x0, x0, 0
localparam data_t NOP = 32'h0000_0013;

// lw and sw both use the word width funct3
localparam funct3_t F3_WORD = 3'b010;

function automatic data_t reg_op(funct7_t f7, funct3_t f3, int rd, int rs1, int rs2);
  return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
endfunction

function automatic data_t addi(int rd, int rs1, int imm);
  return {imm[11:0], rs1[4:0], F3_ADD, rd[4:0], OP_IMM};
endfunction

function automatic data_t load_word(int rd, int rs1, int imm);
  return {imm[11:0], rs1[4:0], F3_WORD, rd[4:0], OP_LOAD};
endfunction

function automatic data_t store_word(int rs2, int rs1, int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OP_STORE};
endfunction

// byte offset from the branch itself, bit 0 dropped
function automatic data_t branch(funct3_t f3, int rs1, int rs2, int off);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic data_t jal(int rd, int off);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
endfunction

`endif

// File: test/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  import rv_isa_pkg::*;

  `include "tb_programs.svh"

  localparam int CLK_HALF        = 50;
  localparam int RESET_CYCLES    = 4;
  localparam int MAX_CYCLES      = 40;
  // five single tests plus ten random rounds
  localparam int PROGRAMS        = 15;
  localparam int WATCHDOG_CYCLES = PROGRAMS * (MAX_CYCLES + RESET_CYCLES + 4);
  localparam int MEM_WORDS       = 64;

  logic      clk = 1'b0;
  logic      rst_i = 1'b1;
  data_t     imem_addr;
  data_t     imem_data;
  data_t     dmem_addr;
  data_t     dmem_wdata;
  logic      dmem_we;
  data_t     dmem_rdata;
  logic      wb_en;
  reg_addr_t wb_rd;
  data_t     wb_data;

  data_t     imem [MEM_WORDS];
  data_t     dmem [MEM_WORDS];
  data_t     prog [$];
  reg_addr_t exp_rd [$];
  data_t     exp_data [$];
  reg_addr_t got_rd [$];
  data_t     got_data [$];
  data_t     exp_st_addr [$];
  data_t     exp_st_data [$];
  data_t     got_st_addr [$];
  data_t     got_st_data [$];

  string test_name;
  int    test_errors;
  int    total_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;

  rv_core uut (
    .clk         (clk),
    .rst_i       (rst_i),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .dmem_addr_o (dmem_addr),
    .dmem_wdata_o(dmem_wdata),
    .dmem_we_o   (dmem_we),
    .dmem_rdata_i(dmem_rdata),
    .wb_en_o     (wb_en),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  initial begin
    forever #CLK_HALF clk = ~clk;
  end

  // word addressed memories, no wait states
  assign imem_data  = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  // commit trace and store trace, sampled mid-cycle
  always @(negedge clk) begin
    if (wb_en) begin
      got_rd.push_back(wb_rd);
      got_data.push_back(wb_data);
    end
    if (dmem_we) begin
      got_st_addr.push_back(dmem_addr);
      got_st_data.push_back(dmem_wdata);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before all tests had finished");
    $display("TEST FAIL");
    $finish;
  end

  function automatic data_t sign_extend(int imm);
    return {{20{imm[11]}}, imm[11:0]};
  endfunction

  function automatic data_t fill_word(int index);
    return 32'hD0D0_0000 ^ data_t'(index * 4);
  endfunction

  task automatic fill_memories();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = NOP;
      dmem[i] <= fill_word(i);
    end
  endtask

  task automatic check_word(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_rd(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0t %s got x%0d expected x%0d", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic start_program();
    prog.delete();
    exp_rd.delete();
    exp_data.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
  endtask

  task automatic expect_write(int rd, data_t value);
    exp_rd.push_back(reg_addr_t'(rd));
    exp_data.push_back(value);
  endtask

  task automatic expect_store(data_t addr, data_t value);
    exp_st_addr.push_back(addr);
    exp_st_data.push_back(value);
  endtask

  // reset, load, then run until fetch is past the program and the pipe has drained
  task automatic run_program();
    data_t done_addr;
    int    cycles;
    @(posedge clk);
    rst_i <= 1'b1;
    fill_memories();
    foreach (prog[i]) begin
      imem[i] = prog[i];
    end
    repeat (RESET_CYCLES) @(posedge clk);
    got_rd.delete();
    got_data.delete();
    got_st_addr.delete();
    got_st_data.delete();
    rst_i <= 1'b0;
    done_addr = data_t'((prog.size() + 6) * 4);
    // first fetch comes from the reset vector
    @(negedge clk);
    check_word("imem_addr_o", imem_addr, RESET_PC);
    cycles = 1;
    while ((imem_addr < done_addr) && (cycles < MAX_CYCLES)) begin
      @(negedge clk);
      cycles++;
    end
    if (imem_addr < done_addr) begin
      $display("%0t: program of %s did not finish within %0d cycles", $time, test_name,
               MAX_CYCLES);
      test_errors++;
    end
  endtask

  task automatic check_trace();
    if (got_rd.size() != exp_rd.size()) begin
      $display("%0t: %s retired %0d register writes where %0d were expected", $time,
               test_name, got_rd.size(), exp_rd.size());
      test_errors++;
    end
    for (int i = 0; (i < got_rd.size()) && (i < exp_rd.size()); i++) begin
      check_rd($sformatf("wb_rd_o #%0d", i), got_rd[i], exp_rd[i]);
      check_word($sformatf("wb_data_o #%0d", i), got_data[i], exp_data[i]);
    end
    if (got_st_addr.size() != exp_st_addr.size()) begin
      $display("%0t: %s made %0d data memory writes where %0d were expected", $time,
               test_name, got_st_addr.size(), exp_st_addr.size());
      test_errors++;
    end
    for (int i = 0; (i < got_st_addr.size()) && (i < exp_st_addr.size()); i++) begin
      check_word($sformatf("dmem_addr_o #%0d", i), got_st_addr[i], exp_st_addr[i]);
      check_word($sformatf("dmem_wdata_o #%0d", i), got_st_data[i], exp_st_data[i]);
    end
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic report_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, test_errors);
    end
  endtask

  // back to back dependencies, operands come from memory and writeback bypass
  task automatic test_alu_chain();
    data_t r1;
    data_t r2;
    data_t r3;
    data_t r4;
    data_t r5;
    data_t r6;
    begin_test("alu_chain");
    start_program();
    r1 = sign_extend(12);
    r2 = sign_extend(-5);
    r3 = r1 + r2;
    r4 = r3 - r1;
    r5 = r4 & r3;
    r6 = r5 | r2;
    prog.push_back(addi(1, 0, 12));
    prog.push_back(addi(2, 0, -5));
    prog.push_back(reg_op('0, F3_ADD, 3, 1, 2));
    prog.push_back(reg_op(F7_SUB, F3_ADD, 4, 3, 1));
    prog.push_back(reg_op('0, F3_AND, 5, 4, 3));
    prog.push_back(reg_op('0, F3_OR, 6, 5, 2));
    prog.push_back(reg_op('0, F3_XOR, 7, 6, 1));
    expect_write(1, r1);
    expect_write(2, r2);
    expect_write(3, r3);
    expect_write(4, r4);
    expect_write(5, r5);
    expect_write(6, r6);
    expect_write(7, r6 ^ r1);
    run_program();
    check_trace();
    report_test();
  endtask

  task automatic test_load_store();
    data_t base;
    data_t value;
    begin_test("load_store");
    start_program();
    base = 32'h40;
    value = 32'h123;
    prog.push_back(addi(1, 0, 'h40));
    prog.push_back(addi(2, 0, 'h123));
    prog.push_back(store_word(2, 1, 8));
    prog.push_back(load_word(3, 1, 8));
    // uses the load result right away
    prog.push_back(reg_op('0, F3_ADD, 4, 3, 2));
    expect_write(1, base);
    expect_write(2, value);
    expect_write(3, value);
    expect_write(4, value + value);
    expect_store(base + 8, value);
    run_program();
    check_trace();
    report_test();
  endtask

  task automatic test_branches();
    begin_test("branches");
    start_program();
    prog.push_back(addi(1, 0, 7));
    prog.push_back(addi(2, 0, 7));
    prog.push_back(branch(F3_BEQ, 1, 2, 12));
    prog.push_back(addi(3, 0, 1));
    prog.push_back(addi(4, 0, 2));
    prog.push_back(addi(5, 0, 3));
    prog.push_back(branch(F3_BNE, 1, 2, 8));
    prog.push_back(addi(6, 0, 4));
    expect_write(1, 32'd7);
    expect_write(2, 32'd7);
    expect_write(5, 32'd3);
    expect_write(6, 32'd4);
    run_program();
    check_trace();
    report_test();
  endtask

  task automatic test_jump();
    data_t link;
    begin_test("jump");
    start_program();
    // jal sits at byte address 4
    link = 32'd4 + 32'd4;
    prog.push_back(addi(1, 0, 1));
    prog.push_back(jal(5, 12));
    prog.push_back(addi(2, 0, 2));
    prog.push_back(addi(3, 0, 3));
    prog.push_back(addi(4, 5, 0));
    expect_write(1, 32'd1);
    expect_write(5, link);
    expect_write(4, link);
    run_program();
    check_trace();
    report_test();
  endtask

  task automatic test_x0_writes();
    begin_test("x0_writes");
    start_program();
    prog.push_back(addi(0, 0, 55));
    prog.push_back(reg_op('0, F3_ADD, 3, 0, 0));
    prog.push_back(addi(1, 0, 9));
    prog.push_back(reg_op('0, F3_ADD, 2, 0, 1));
    expect_write(3, 32'd0);
    expect_write(1, 32'd9);
    expect_write(2, 32'd9);
    run_program();
    check_trace();
    report_test();
  endtask

  task automatic test_random_alu();
    data_t a;
    data_t b;
    data_t va;
    data_t vb;
    begin_test("random_alu");
    for (int round = 0; round < 10; round++) begin
      start_program();
      a = $urandom;
      b = $urandom;
      va = sign_extend(int'(a));
      vb = sign_extend(int'(b));
      prog.push_back(addi(1, 0, int'(a)));
      prog.push_back(addi(2, 0, int'(b)));
      prog.push_back(reg_op('0, F3_ADD, 3, 1, 2));
      prog.push_back(reg_op(F7_SUB, F3_ADD, 4, 1, 2));
      prog.push_back(reg_op('0, F3_XOR, 5, 1, 2));
      expect_write(1, va);
      expect_write(2, vb);
      expect_write(3, va + vb);
      expect_write(4, va - vb);
      expect_write(5, va ^ vb);
      run_program();
      check_trace();
    end
    report_test();
  endtask

  initial begin
    void'($urandom(26));
    fill_memories();
    test_alu_chain();
    test_load_store();
    test_branches();
    test_jump();
    test_x0_writes();
    test_random_alu();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: rv_core.f
+incdir+test
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/fetch_stage.sv
hdl/pipe_reg.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/hazard_unit.sv
hdl/rv_core.sv
test/rv_core_tb.sv

// File: Makefile
# RTL sources in compile order, taken from the file list
RTL := $(shell grep '^hdl/' rv_core.f)

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module rv_core $(RTL)

sim:
	verilator --binary -j 0 -f rv_core.f --top-module rv_core_tb -o rv_core_sim
	./obj_dir/rv_core_sim | tee /dev/stderr | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
